// ==== Bender.yml ====
package:
  name: rob_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/rob_core_pkg.sv
      - hw/rob_dispatch.sv
      - hw/rob_execute.sv
      - hw/rob_buffer.sv
      - hw/rob_regfile.sv
      - hw/rob_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/rob_core_properties.sv
      - test/rob_core_tb.sv

// ==== hw/rob_buffer.sv ====
`timescale 1ns/1ps
`include "rob_core_macros.svh"

module rob_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alloc,
    input  rob_core_pkg::rob_op_t      alloc_op,
    input  logic [`REG_ADDR_W-1:0]     alloc_rd,
    input  logic [`XLEN-1:0]           alloc_imm,
    output logic [`ROB_TAG_W-1:0]      alloc_tag,
    output logic                       rob_full,
    input  logic [`ROB_TAG_W-1:0]      lookup1_tag,
    input  logic [`ROB_TAG_W-1:0]      lookup2_tag,
    output logic                       lookup1_done,
    output logic [`XLEN-1:0]           lookup1_value,
    output logic                       lookup2_done,
    output logic [`XLEN-1:0]           lookup2_value,
    input  logic                       wb_alu_valid,
    input  logic [`ROB_TAG_W-1:0]      wb_alu_tag,
    input  logic [`XLEN-1:0]           wb_alu_value,
    input  logic                       wb_mul_valid,
    input  logic [`ROB_TAG_W-1:0]      wb_mul_tag,
    input  logic [`XLEN-1:0]           wb_mul_value,
    output logic                       commit_valid,
    output logic [`REG_ADDR_W-1:0]     commit_rd,
    output logic [`XLEN-1:0]           commit_value,
    output logic [`ROB_TAG_W-1:0]      commit_tag
);
    import rob_core_pkg::*;

    rob_op_t                   ent_op    [`ROB_DEPTH];
    logic [`REG_ADDR_W-1:0]    ent_rd    [`ROB_DEPTH];
    logic [`XLEN-1:0]          ent_val   [`ROB_DEPTH];
    rob_entry_t                ent_state [`ROB_DEPTH];
    logic [`ROB_TAG_W-1:0]     head;
    logic [`ROB_TAG_W-1:0]     tail;
    logic                      retire;

    // step a pointer, skipping tag 0.
    function automatic logic [`ROB_TAG_W-1:0] next_ptr(input logic [`ROB_TAG_W-1:0] p);
        if (p == `ROB_TAG_W'(`ROB_DEPTH - 1))
            return `ROB_TAG_W'(1);
        return p + 1'b1;
    endfunction

    assign alloc_tag = tail;
    assign rob_full  = next_ptr(tail) == head;
    assign retire    = ent_state[head] == ENT_DONE;

    // entry 0 stays free, so tag 0 never reads as done.
    assign lookup1_done  = ent_state[lookup1_tag] == ENT_DONE;
    assign lookup1_value = ent_val[lookup1_tag];
    assign lookup2_done  = ent_state[lookup2_tag] == ENT_DONE;
    assign lookup2_value = ent_val[lookup2_tag];

    always_ff @(posedge clk) begin
        if (!rst) begin
            head <= `ROB_TAG_W'(1);
            tail <= `ROB_TAG_W'(1);
            for (int i = 0; i < `ROB_DEPTH; i++)
                ent_state[i] <= ENT_FREE;
        end else begin
            if (alloc) begin
                ent_state[tail] <= (alloc_op == OP_LUI || alloc_op == OP_NOP) ? ENT_DONE
                                                                               : ENT_BUSY;
                tail <= next_ptr(tail);
            end
            if (wb_alu_valid)
                ent_state[wb_alu_tag] <= ENT_DONE;
            if (wb_mul_valid)
                ent_state[wb_mul_tag] <= ENT_DONE;
            if (retire) begin
                ent_state[head] <= ENT_FREE;
                head <= next_ptr(head);
            end
        end
    end

    // entry payload.
    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_op[tail]  <= alloc_op;
            ent_rd[tail]  <= alloc_rd;
            ent_val[tail] <= alloc_imm;  // final value for lui.
        end
        if (wb_alu_valid)
            ent_val[wb_alu_tag] <= wb_alu_value;
        if (wb_mul_valid)
            ent_val[wb_mul_tag] <= wb_mul_value;
    end

    always_ff @(posedge clk) begin
        if (!rst)
            commit_valid <= 1'b0;
        else
            commit_valid <= retire;
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_rd    <= (ent_op[head] == OP_NOP) ? '0 : ent_rd[head];
            commit_value <= ent_val[head];
            commit_tag   <= head;
        end
    end

endmodule

// ==== hw/rob_core.sv ====
`timescale 1ns/1ps
`include "rob_core_macros.svh"

module rob_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ins_valid,
    input  rob_core_pkg::rob_op_t     ins_op,
    input  logic [`REG_ADDR_W-1:0]    ins_rd,
    input  logic [`REG_ADDR_W-1:0]    ins_rs1,
    input  logic [`REG_ADDR_W-1:0]    ins_rs2,
    input  logic [`XLEN-1:0]          ins_imm,
    input  logic                      has_imm,
    output logic                      ins_ready,
    output logic                      commit_valid,
    output logic [`REG_ADDR_W-1:0]    commit_rd,
    output logic [`XLEN-1:0]          commit_value
);
    import rob_core_pkg::*;

    logic                      rob_full, disp_stall, alloc;
    rob_op_t                   alloc_op, disp_op;
    logic [`REG_ADDR_W-1:0]    alloc_rd, rf_rs1, rf_rs2;
    logic [`XLEN-1:0]          alloc_imm, rf_val1, rf_val2;
    logic [`ROB_TAG_W-1:0]     alloc_tag, rf_q1, rf_q2, commit_tag;
    logic [`ROB_TAG_W-1:0]     lookup1_tag, lookup2_tag;
    logic                      lookup1_done, lookup2_done;
    logic [`XLEN-1:0]          lookup1_value, lookup2_value;
    logic                      wb_alu_valid, wb_mul_valid, disp_valid;
    logic [`ROB_TAG_W-1:0]     wb_alu_tag, wb_mul_tag, disp_tag, disp_q1, disp_q2;
    logic [`XLEN-1:0]          wb_alu_value, wb_mul_value, disp_val1, disp_val2;

    rob_dispatch i_dispatch (.*);

    rob_execute i_execute (.*);

    rob_buffer i_buffer (.*);

    rob_regfile i_regfile (.*);

endmodule

// ==== hw/rob_core_macros.svh ====
`ifndef ROB_CORE_MACROS_SVH
`define ROB_CORE_MACROS_SVH

`define XLEN        32
`define ROB_TAG_W   3
`define ROB_DEPTH   8   // tag 0 is never allocated.
`define REG_ADDR_W  5
`define NREGS       32

// multiplier stages between issue and the result bus.
`define MUL_LAT     3

`endif

// ==== hw/rob_core_pkg.sv ====
package rob_core_pkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLT,  // signed.
        OP_LUI,  // done at allocation.
        OP_MUL
    } rob_op_t;

    // life of a buffer entry.
    typedef enum logic [1:0] {
        ENT_FREE,
        ENT_BUSY,
        ENT_DONE
    } rob_entry_t;

endpackage

// ==== hw/rob_dispatch.sv ====
`timescale 1ns/1ps
`include "rob_core_macros.svh"

module rob_dispatch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ins_valid,
    input  rob_core_pkg::rob_op_t      ins_op,
    input  logic [`REG_ADDR_W-1:0]     ins_rd,
    input  logic [`REG_ADDR_W-1:0]     ins_rs1,
    input  logic [`REG_ADDR_W-1:0]     ins_rs2,
    input  logic [`XLEN-1:0]           ins_imm,
    input  logic                       has_imm,
    output logic                       ins_ready,
    input  logic                       rob_full,
    input  logic                       disp_stall,
    output logic                       alloc,
    output rob_core_pkg::rob_op_t      alloc_op,
    output logic [`REG_ADDR_W-1:0]     alloc_rd,
    output logic [`XLEN-1:0]           alloc_imm,
    input  logic [`ROB_TAG_W-1:0]      alloc_tag,
    output logic [`REG_ADDR_W-1:0]     rf_rs1,
    output logic [`REG_ADDR_W-1:0]     rf_rs2,
    input  logic [`XLEN-1:0]           rf_val1,
    input  logic [`ROB_TAG_W-1:0]      rf_q1,
    input  logic [`XLEN-1:0]           rf_val2,
    input  logic [`ROB_TAG_W-1:0]      rf_q2,
    output logic [`ROB_TAG_W-1:0]      lookup1_tag,
    output logic [`ROB_TAG_W-1:0]      lookup2_tag,
    input  logic                       lookup1_done,
    input  logic [`XLEN-1:0]           lookup1_value,
    input  logic                       lookup2_done,
    input  logic [`XLEN-1:0]           lookup2_value,
    input  logic                       wb_alu_valid,
    input  logic [`ROB_TAG_W-1:0]      wb_alu_tag,
    input  logic [`XLEN-1:0]           wb_alu_value,
    input  logic                       wb_mul_valid,
    input  logic [`ROB_TAG_W-1:0]      wb_mul_tag,
    input  logic [`XLEN-1:0]           wb_mul_value,
    output logic                       disp_valid,
    output rob_core_pkg::rob_op_t      disp_op,
    output logic [`ROB_TAG_W-1:0]      disp_tag,
    output logic [`XLEN-1:0]           disp_val1,
    output logic [`ROB_TAG_W-1:0]      disp_q1,
    output logic [`XLEN-1:0]           disp_val2,
    output logic [`ROB_TAG_W-1:0]      disp_q2
);
    import rob_core_pkg::*;

    logic                          accept;
    logic                          hold;
    logic                          fwd;
    logic [`ROB_TAG_W+`XLEN-1:0]   op1;
    logic [`ROB_TAG_W+`XLEN-1:0]   op2;
    logic [`ROB_TAG_W+`XLEN-1:0]   held1;
    logic [`ROB_TAG_W+`XLEN-1:0]   held2;

    // returns {tag, value}; the tag drops to 0 once the value is known.
    function automatic logic [`ROB_TAG_W+`XLEN-1:0] resolve(
        input logic [`ROB_TAG_W-1:0] q,
        input logic [`XLEN-1:0]      v,
        input logic                  done,
        input logic [`XLEN-1:0]      done_v
    );
        logic [`ROB_TAG_W+`XLEN-1:0] r;
        r = {q, v};
        if (q != '0) begin
            if (done)
                r = {{`ROB_TAG_W{1'b0}}, done_v};
            else if (wb_alu_valid && wb_alu_tag == q)
                r = {{`ROB_TAG_W{1'b0}}, wb_alu_value};
            else if (wb_mul_valid && wb_mul_tag == q)
                r = {{`ROB_TAG_W{1'b0}}, wb_mul_value};
        end
        return r;
    endfunction

    assign hold      = disp_valid && disp_stall;
    assign ins_ready = !rob_full && !hold;
    assign accept    = ins_valid && ins_ready;
    assign fwd       = (ins_op != OP_LUI) && (ins_op != OP_NOP);  // these finish in the buffer.

    assign alloc     = accept;
    assign alloc_op  = ins_op;
    assign alloc_rd  = (ins_op == OP_NOP) ? '0 : ins_rd;  // nop renames nothing.
    assign alloc_imm = ins_imm;

    assign rf_rs1      = ins_rs1;
    assign rf_rs2      = ins_rs2;
    assign lookup1_tag = rf_q1;
    assign lookup2_tag = rf_q2;

    always_comb begin
        op1 = resolve(rf_q1, rf_val1, lookup1_done, lookup1_value);
        op2 = has_imm ? {{`ROB_TAG_W{1'b0}}, ins_imm}
                      : resolve(rf_q2, rf_val2, lookup2_done, lookup2_value);
        // a held instruction still has to see results going by.
        held1 = resolve(disp_q1, disp_val1, 1'b0, disp_val1);
        held2 = resolve(disp_q2, disp_val2, 1'b0, disp_val2);
    end

    always_ff @(posedge clk) begin
        if (!rst)
            disp_valid <= 1'b0;
        else if (accept)
            disp_valid <= fwd;
        else if (!hold)
            disp_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp_op              <= ins_op;
            disp_tag             <= alloc_tag;
            {disp_q1, disp_val1} <= op1;
            {disp_q2, disp_val2} <= op2;
        end else if (hold) begin
            {disp_q1, disp_val1} <= held1;
            {disp_q2, disp_val2} <= held2;
        end
    end

endmodule

// ==== hw/rob_execute.sv ====
`timescale 1ns/1ps
`include "rob_core_macros.svh"

module rob_execute (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       disp_valid,
    input  rob_core_pkg::rob_op_t      disp_op,
    input  logic [`ROB_TAG_W-1:0]      disp_tag,
    input  logic [`XLEN-1:0]           disp_val1,
    input  logic [`ROB_TAG_W-1:0]      disp_q1,
    input  logic [`XLEN-1:0]           disp_val2,
    input  logic [`ROB_TAG_W-1:0]      disp_q2,
    output logic                       disp_stall,
    output logic                       wb_alu_valid,
    output logic [`ROB_TAG_W-1:0]      wb_alu_tag,
    output logic [`XLEN-1:0]           wb_alu_value,
    output logic                       wb_mul_valid,
    output logic [`ROB_TAG_W-1:0]      wb_mul_tag,
    output logic [`XLEN-1:0]           wb_mul_value
);
    import rob_core_pkg::*;

    logic                     slot_busy;
    rob_op_t                  slot_op;
    logic [`ROB_TAG_W-1:0]    slot_tag;
    logic [`XLEN-1:0]         slot_v1;
    logic [`ROB_TAG_W-1:0]    slot_q1;
    logic [`XLEN-1:0]         slot_v2;
    logic [`ROB_TAG_W-1:0]    slot_q2;
    logic                     can_issue;
    logic                     take;
    logic [`XLEN-1:0]         alu_res;
    logic                     mul_v [`MUL_LAT];
    logic [`ROB_TAG_W-1:0]    mul_t [`MUL_LAT];
    logic [`XLEN-1:0]         mul_p [`MUL_LAT];

    // {tag, value} after watching both result buses.
    function automatic logic [`ROB_TAG_W+`XLEN-1:0] snoop(
        input logic [`ROB_TAG_W-1:0] q,
        input logic [`XLEN-1:0]      v
    );
        if (q != '0 && wb_alu_valid && wb_alu_tag == q)
            return {{`ROB_TAG_W{1'b0}}, wb_alu_value};
        if (q != '0 && wb_mul_valid && wb_mul_tag == q)
            return {{`ROB_TAG_W{1'b0}}, wb_mul_value};
        return {q, v};
    endfunction

    assign can_issue  = slot_busy && slot_q1 == '0 && slot_q2 == '0;
    assign disp_stall = slot_busy && !can_issue;
    assign take       = disp_valid && !disp_stall;

    always_ff @(posedge clk) begin
        if (!rst)
            slot_busy <= 1'b0;
        else if (take)
            slot_busy <= 1'b1;
        else if (can_issue)
            slot_busy <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            slot_op            <= disp_op;
            slot_tag           <= disp_tag;
            {slot_q1, slot_v1} <= snoop(disp_q1, disp_val1);
            {slot_q2, slot_v2} <= snoop(disp_q2, disp_val2);
        end else begin
            {slot_q1, slot_v1} <= snoop(slot_q1, slot_v1);
            {slot_q2, slot_v2} <= snoop(slot_q2, slot_v2);
        end
    end

    always_comb begin
        case (slot_op)
            OP_ADD:  alu_res = slot_v1 + slot_v2;
            OP_SUB:  alu_res = slot_v1 - slot_v2;
            OP_AND:  alu_res = slot_v1 & slot_v2;
            OP_OR:   alu_res = slot_v1 | slot_v2;
            OP_XOR:  alu_res = slot_v1 ^ slot_v2;
            OP_SLL:  alu_res = slot_v1 << slot_v2[4:0];
            OP_SRL:  alu_res = slot_v1 >> slot_v2[4:0];
            OP_SLT:  alu_res = ($signed(slot_v1) < $signed(slot_v2)) ? 32'd1 : 32'd0;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst)
            wb_alu_valid <= 1'b0;
        else
            wb_alu_valid <= can_issue && slot_op != OP_MUL;
    end

    always_ff @(posedge clk) begin
        wb_alu_tag   <= slot_tag;
        wb_alu_value <= alu_res;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `MUL_LAT; i++)
                mul_v[i] <= 1'b0;
        end else begin
            mul_v[0] <= can_issue && slot_op == OP_MUL;
            for (int i = 1; i < `MUL_LAT; i++)
                mul_v[i] <= mul_v[i-1];
        end
    end

    always_ff @(posedge clk) begin
        mul_t[0] <= slot_tag;
        mul_p[0] <= slot_v1 * slot_v2;  // low half only.
        for (int i = 1; i < `MUL_LAT; i++) begin
            mul_t[i] <= mul_t[i-1];
            mul_p[i] <= mul_p[i-1];
        end
    end

    assign wb_mul_valid = mul_v[`MUL_LAT-1];
    assign wb_mul_tag   = mul_t[`MUL_LAT-1];
    assign wb_mul_value = mul_p[`MUL_LAT-1];

endmodule

// ==== hw/rob_regfile.sv ====
`timescale 1ns/1ps
`include "rob_core_macros.svh"

module rob_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`REG_ADDR_W-1:0]    rf_rs1,
    input  logic [`REG_ADDR_W-1:0]    rf_rs2,
    output logic [`XLEN-1:0]          rf_val1,
    output logic [`ROB_TAG_W-1:0]     rf_q1,
    output logic [`XLEN-1:0]          rf_val2,
    output logic [`ROB_TAG_W-1:0]     rf_q2,
    input  logic                      alloc,
    input  logic [`REG_ADDR_W-1:0]    alloc_rd,
    input  logic [`ROB_TAG_W-1:0]     alloc_tag,
    input  logic                      commit_valid,
    input  logic [`REG_ADDR_W-1:0]    commit_rd,
    input  logic [`XLEN-1:0]          commit_value,
    input  logic [`ROB_TAG_W-1:0]     commit_tag
);

    logic [`XLEN-1:0]         regs [`NREGS];
    logic [`ROB_TAG_W-1:0]    tags [`NREGS];
    logic                     byp1;
    logic                     byp2;

    // the buffer has already freed a committing entry, so pass it through here.
    assign byp1 = commit_valid && commit_rd == rf_rs1;
    assign byp2 = commit_valid && commit_rd == rf_rs2;

    always_comb begin
        rf_val1 = byp1 ? commit_value : regs[rf_rs1];
        rf_q1   = (byp1 && tags[rf_rs1] == commit_tag) ? '0 : tags[rf_rs1];
        rf_val2 = byp2 ? commit_value : regs[rf_rs2];
        rf_q2   = (byp2 && tags[rf_rs2] == commit_tag) ? '0 : tags[rf_rs2];
        if (rf_rs1 == '0) begin
            rf_val1 = '0;  // x0.
            rf_q1   = '0;
        end
        if (rf_rs2 == '0) begin
            rf_val2 = '0;
            rf_q2   = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid && commit_rd != '0)
            regs[commit_rd] <= commit_value;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `NREGS; i++)
                tags[i] <= '0;
        end else begin
            if (commit_valid && commit_rd != '0 && tags[commit_rd] == commit_tag)
                tags[commit_rd] <= '0;
            if (alloc && alloc_rd != '0)
                tags[alloc_rd] <= alloc_tag;  // newer producer wins.
        end
    end

endmodule

// ==== rob_core.f ====
+incdir+hw
hw/rob_core_pkg.sv
hw/rob_dispatch.sv
hw/rob_execute.sv
hw/rob_buffer.sv
hw/rob_regfile.sv
hw/rob_core.sv
test/rob_core_properties.sv
test/rob_core_tb.sv

// ==== test/rob_core_properties.sv ====
`timescale 1ns/1ps
`include "rob_core_macros.svh"

module rob_core_properties (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alloc,
    input  logic                          rob_full,
    input  logic [`ROB_TAG_W-1:0]         head,
    input  logic [`ROB_TAG_W-1:0]         tail,
    input  rob_core_pkg::rob_entry_t      ent_state [`ROB_DEPTH],
    input  logic                          wb_alu_valid,
    input  logic [`ROB_TAG_W-1:0]         wb_alu_tag,
    input  logic                          wb_mul_valid,
    input  logic [`ROB_TAG_W-1:0]         wb_mul_tag,
    input  logic                          commit_valid
);
    import rob_core_pkg::*;

    no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst)
        !(alloc && rob_full))
        else $error("allocation while the reorder buffer is full");

    pointers_nonzero: assert property (@(posedge clk) disable iff (!rst)
        head != '0 && tail != '0)
        else $error("head or tail pointer reached entry 0");

    // a result may only land on an entry that waits for it.
    alu_wb_busy: assert property (@(posedge clk) disable iff (!rst)
        wb_alu_valid |-> wb_alu_tag != '0 && ent_state[wb_alu_tag] == ENT_BUSY)
        else $error("alu write-back to a tag that is not busy");

    mul_wb_busy: assert property (@(posedge clk) disable iff (!rst)
        wb_mul_valid |-> wb_mul_tag != '0 && ent_state[wb_mul_tag] == ENT_BUSY)
        else $error("multiplier write-back to a tag that is not busy");

    commit_known: assert property (@(posedge clk) disable iff (!rst)
        !$isunknown(commit_valid))
        else $error("commit_valid is unknown");

endmodule

bind rob_buffer rob_core_properties i_properties (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc),
    .rob_full     (rob_full),
    .head         (head),
    .tail         (tail),
    .ent_state    (ent_state),
    .wb_alu_valid (wb_alu_valid),
    .wb_alu_tag   (wb_alu_tag),
    .wb_mul_valid (wb_mul_valid),
    .wb_mul_tag   (wb_mul_tag),
    .commit_valid (commit_valid)
);

// ==== test/rob_core_tb.sv ====
`timescale 1ns/1ps
`include "rob_core_macros.svh"

module rob_core_tb;
    import rob_core_pkg::*;

    typedef struct {
        string                    name;
        rob_op_t                  op;
        logic [`REG_ADDR_W-1:0]   rd;
        logic [`REG_ADDR_W-1:0]   rs1;
        logic [`REG_ADDR_W-1:0]   rs2;
        logic [`XLEN-1:0]         imm;
        logic                     has_imm;
    } instr_t;

    typedef struct {
        string                    name;
        logic [`REG_ADDR_W-1:0]   rd;
        logic [`XLEN-1:0]         value;
    } expect_t;

    logic                      clk;
    logic                      rst;
    logic                      ins_valid;
    rob_op_t                   ins_op;
    logic [`REG_ADDR_W-1:0]    ins_rd;
    logic [`REG_ADDR_W-1:0]    ins_rs1;
    logic [`REG_ADDR_W-1:0]    ins_rs2;
    logic [`XLEN-1:0]          ins_imm;
    logic                      has_imm;
    logic                      ins_ready;
    logic                      commit_valid;
    logic [`REG_ADDR_W-1:0]    commit_rd;
    logic [`XLEN-1:0]          commit_value;

    instr_t            stim_q [$];
    expect_t           exp_q [$];
    logic [`XLEN-1:0]  mregs [`NREGS];
    int                errors = 0;
    int                checks = 0;
    int                n_accepted = 0;
    int                n_commits = 0;
    int                stall_seen = 0;
    int                limit_cycles = 0;

    rob_core i_rob_core (.*);

    always #20 clk = ~clk;

    function automatic logic [`XLEN-1:0] ref_result(input rob_op_t op,
                                                    input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            OP_LUI:  return b;
            OP_MUL:  return a * b;  // low word of the product.
            default: return '0;
        endcase
    endfunction

    task automatic check(input string name, input logic [`XLEN-1:0] expected,
                         input logic [`XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic push_instr(input string name, input rob_op_t op, input int rd,
                              input int rs1, input int rs2, input logic [`XLEN-1:0] imm,
                              input bit imm_sel);
        instr_t in;
        in.name    = name;
        in.op      = op;
        in.rd      = rd;
        in.rs1     = rs1;
        in.rs2     = rs2;
        in.imm     = imm;
        in.has_imm = imm_sel || op == OP_LUI;
        stim_q.push_back(in);
    endtask

    // executes an accepted instruction on the model registers.
    task automatic model_accept(input instr_t in);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        expect_t e;
        a = mregs[in.rs1];
        b = in.has_imm ? in.imm : mregs[in.rs2];
        e.name  = in.name;
        e.rd    = in.rd;
        e.value = ref_result(in.op, a, b);
        if (in.rd != 0)
            mregs[in.rd] = e.value;
        exp_q.push_back(e);
        n_accepted++;
    endtask

    task automatic build_stimulus();
        rob_op_t op;
        for (int r = 1; r < `NREGS; r++)
            push_instr("init_lui", OP_LUI, r, 0, 0, $urandom, 1);
        for (int k = int'(OP_ADD); k <= int'(OP_SLT); k++) begin
            op = rob_op_t'(k);
            push_instr("alu_reg", op, 20 + k, k, k + 8, 0, 0);
            push_instr("alu_imm", op, 20 + k, k + 1, 0, $urandom, 1);
        end
        push_instr("mul_order", OP_MUL, 11, 1, 2, 0, 0);
        push_instr("mul_order", OP_ADD, 12, 3, 4, 0, 0);
        push_instr("mul_order", OP_ADD, 13, 5, 6, 0, 0);
        push_instr("mul_order", OP_ADD, 14, 7, 8, 0, 0);
        push_instr("mul_chain", OP_ADD, 15, 11, 1, 0, 0);
        push_instr("mul_chain", OP_MUL, 16, 11, 11, 0, 0);
        push_instr("mul_chain", OP_SUB, 17, 16, 15, 0, 0);
        push_instr("lui_x0", OP_LUI, 9, 0, 0, 32'habcd_e000, 1);
        push_instr("lui_x0", OP_ADD, 0, 1, 2, 0, 0);
        push_instr("lui_x0", OP_LUI, 0, 0, 0, 32'h1234_5000, 1);
        push_instr("lui_x0", OP_ADD, 18, 0, 3, 0, 0);
        push_instr("lui_x0", OP_OR, 19, 0, 0, 32'h55, 1);
        // a slow chain at the head while luis allocate behind it.
        for (int n = 0; n < 3; n++) begin
            for (int m = 0; m < 3; m++)
                push_instr("backpressure", OP_MUL, 1, 1, 2, 0, 0);
            for (int m = 0; m < 8; m++)
                push_instr("backpressure", OP_LUI, 10 + m, 0, 0, $urandom, 1);
        end
        for (int n = 0; n < 300; n++) begin
            op = rob_op_t'($urandom_range(int'(OP_ADD), int'(OP_MUL)));
            push_instr("random", op, $urandom_range(0, 31), $urandom_range(0, 31),
                       $urandom_range(0, 31), $urandom, $urandom_range(0, 1));
        end
    endtask

    // holds each instruction until it is accepted.
    task automatic drive_all();
        instr_t in;
        logic   accepted;
        @(posedge clk);
        #2;
        while (stim_q.size() > 0) begin
            in        = stim_q.pop_front();
            ins_valid = 1'b1;
            ins_op    = in.op;
            ins_rd    = in.rd;
            ins_rs1   = in.rs1;
            ins_rs2   = in.rs2;
            ins_imm   = in.imm;
            has_imm   = in.has_imm;
            accepted  = 1'b0;
            while (!accepted) begin
                #1;
                if (ins_ready) begin
                    accepted = 1'b1;
                    model_accept(in);
                end else if (in.name == "backpressure") begin
                    stall_seen++;
                end
                @(posedge clk);
                #2;
            end
        end
        ins_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("commit of rd %0d with no instruction outstanding", commit_rd);
            end else begin
                e = exp_q.pop_front();
                check({e.name, " rd"}, e.rd, commit_rd);
                check({e.name, " value"}, e.value, commit_value);
            end
            n_commits++;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: %0d of %0d instructions committed after %0d cycles",
                 n_commits, n_accepted, limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        ins_valid = 1'b0;
        ins_op    = OP_NOP;
        ins_rd    = '0;
        ins_rs1   = '0;
        ins_rs2   = '0;
        ins_imm   = '0;
        has_imm   = 1'b0;
        for (int r = 0; r < `NREGS; r++)
            mregs[r] = '0;
        void'($urandom(32'h87b1));
        build_stimulus();
        limit_cycles = 40 * stim_q.size() + 200;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check("idle commit_valid", 0, commit_valid);
            check("idle ins_ready", 1, ins_ready);
        end
        drive_all();
        while (n_commits < n_accepted)
            @(negedge clk);
        repeat (10) @(negedge clk);  // catch any extra retirement.
        if (stall_seen == 0) begin
            errors++;
            $display("ins_ready never dropped during the back-pressure burst");
        end
        check("commit count", n_accepted, n_commits);
        $display("checks %0d, errors %0d, accepted %0d, committed %0d",
                 checks, errors, n_accepted, n_commits);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
